// ==== flist.f ====
verilog/s16_pkg.sv
verilog/s16_cen_gen.sv
verilog/s16_cab_io.sv
verilog/s16_ppi.sv
verilog/s16_vblank_irq.sv
verilog/s16_bus_ctrl.sv
verilog/s16_main_glue.sv
sim/tb_s16_main_glue.sv

// ==== Makefile ====
TOP := tb_s16_main_glue

.PHONY: all lint clean

all:
	verilator --binary --timing --timescale 1ns/10ps -j 0 -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== sim/tb_s16_main_glue.sv ====
/* Testbench for the main CPU glue: table of CPU bus cycles, PPI outputs,
   VBLANK interrupt and clock-enable rate */
`timescale 1ns/10ps
`default_nettype none

module tb_s16_main_glue import s16_pkg::*; ();

    localparam int cen_num     = 29;
    localparam int cen_den     = 146;
    localparam int idle_cycles = 1460;
    localparam int bus_timeout = 200;  // Clock cycles per bus cycle

    // Fixed memory words
    localparam logic [15:0] rom_word  = 16'h1234;
    localparam logic [15:0] ram_word  = 16'h5678;
    localparam logic [15:0] char_word = 16'h2222;
    localparam logic [15:0] pal_word  = 16'h3333;
    localparam logic [15:0] obj_word  = 16'h4444;

    // Chip select mask bits {rom, vram, char, objram, pal, ram}
    localparam logic [5:0] cs_rom  = 6'b100000;
    localparam logic [5:0] cs_vram = 6'b010000;
    localparam logic [5:0] cs_char = 6'b001000;
    localparam logic [5:0] cs_obj  = 6'b000100;
    localparam logic [5:0] cs_pal  = 6'b000010;
    localparam logic [5:0] cs_ram  = 6'b000001;
    localparam logic [5:0] cs_none = 6'b000000;

    // Cabinet inputs
    localparam logic [7:0]  joy1_val    = 8'hc5;
    localparam logic [7:0]  joy2_val    = 8'h3a;
    localparam logic [15:0] ana1_val    = 16'h9c47;
    localparam logic [15:0] ana2_val    = 16'h28e1;
    localparam logic [1:0]  start_val   = 2'b10;
    localparam logic [1:0]  coin_val    = 2'b01;
    localparam logic        service_val = 1'b1;
    localparam logic        test_val    = 1'b0;
    localparam logic [7:0]  dip_a_val   = 8'h5c;
    localparam logic [7:0]  dip_b_val   = 8'ha3;

    typedef struct packed {
        logic [23:0] byte_addr;
        logic        rd_wr;
        logic [15:0] wd;
        logic [7:0]  game;
        logic [15:0] rd_exp;
        logic        err;     // Bus error expected
        logic [5:0]  cs;
    } step_t;

    logic clk = 1'b0;
    logic rst;
    logic [7:0] game_id;
    logic [addr_w:1] addr;
    logic as_n, uds_n, lds_n, rnw;
    logic [2:0] fc;
    logic [data_w-1:0] wdata, rdata;
    logic dtack_n, berr_n, irq_n, cpu_cen, cpu_cenb;
    logic rom_cs, char_cs, objram_cs, pal_cs, vram_cs, ram_cs;
    logic [17:1] rom_addr;
    logic [data_w-1:0] rom_data, ram_data, char_dout, pal_dout, obj_dout;
    logic rom_ok = 1'b0;
    logic ram_ok = 1'b0;
    logic [8:0] vdump;
    logic hstart, flip, colscr_en, rowscr_en;
    logic [7:0] snd_latch;
    logic snd_irqn, snd_ack;
    logic [7:0] joystick1, joystick2;
    logic [15:0] joyana1, joyana2;
    logic [1:0] start_button, coin_input;
    logic service, dip_test;
    logic [7:0] dipsw_a, dipsw_b;

    logic [31:0] rnd = 32'd75244;
    logic [1:0]  rom_wait = 2'd0;
    logic [1:0]  ram_wait = 2'd0;
    step_t       steps[$];

    s16_main_glue #(.cen_num(cen_num), .cen_den(cen_den)) u_s16_main_glue (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Connector wiring 1, 0, 3, 2, 7, 5, 4, 6 from bit 7 down
    function automatic logic [7:0] wired_joy(input logic [7:0] j);
        return {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    function automatic logic [7:0] cab_word0(input logic [7:0] g);
        logic [7:0] w;
        w = {2'b11, start_val, service_val, test_val, coin_val};
        if (g == game_sdi) w[7:6] = {joy2_val[4], joy1_val[4]};  // Fire buttons
        return w;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, want);
            $display("Verification failed");
            $fatal(1, "Stopped on mismatch");
        end
    endtask

    // Random memory latency of 0 to 3 cycles after each select
    always @(negedge clk) begin
        // DTACK has to wait for the ok level seen on the last rising edge
        if ((rom_cs && !rom_ok) || ((ram_cs || vram_cs) && !ram_ok))
            compare("dtack_n while waiting", 32'(dtack_n), 32'd1);
        rnd = xorshift(rnd);
        if (!rom_cs) rom_wait = rnd[1:0];
        else if (rom_wait != 2'd0) rom_wait = rom_wait - 2'd1;
        if (!(ram_cs || vram_cs)) ram_wait = rnd[3:2];
        else if (ram_wait != 2'd0) ram_wait = ram_wait - 2'd1;
        rom_ok = rom_cs && rom_wait == 2'd0;
        ram_ok = (ram_cs || vram_cs) && ram_wait == 2'd0;
    end

    task automatic abort_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Verification failed");
        $fatal(1, "Stopped on timeout");
    endtask

    task automatic read_entry(input logic [23:0] a, input logic [7:0] g,
                              input logic [15:0] e, input logic [5:0] cs);
        steps.push_back({a, 1'b1, 16'h0000, g, e, 1'b0, cs});
    endtask

    task automatic write_entry(input logic [23:0] a, input logic [15:0] w, input logic [5:0] cs);
        steps.push_back({a, 1'b0, w, game_default, 16'h0000, 1'b0, cs});
    endtask

    task automatic fault_entry(input logic [23:0] a);
        steps.push_back({a, 1'b1, 16'h0000, game_default, 16'hffff, 1'b1, cs_none});
    endtask

    // One CPU cycle from falling edge to falling edge
    task automatic run_step(input step_t s, input logic [2:0] f);
        int n;
        logic dt, be;
        logic [15:0] rd;
        logic [5:0] cs;
        game_id = s.game;
        addr    = s.byte_addr[23:1];
        rnw     = s.rd_wr;
        wdata   = s.wd;
        fc      = f;
        uds_n   = 1'b0;
        lds_n   = 1'b0;
        as_n    = 1'b0;
        n = 0;
        while (dtack_n && berr_n) begin
            @(negedge clk);
            n++;
            if (n > bus_timeout) abort_timeout("DTACK or bus error");
        end
        rd = rdata;
        dt = dtack_n;
        be = berr_n;
        cs = {rom_cs, vram_cs, char_cs, objram_cs, pal_cs, ram_cs};
        compare("rom_addr", 32'(rom_addr), 32'(s.byte_addr[17:1]));
        if (!be) begin
            repeat (3) begin  // DTACK must stay off after a bus error
                @(negedge clk);
                if (!dtack_n) dt = 1'b0;
            end
        end
        as_n  = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        @(negedge clk);
        compare("dtack_n", 32'(dt), 32'(s.err));
        compare("berr_n", 32'(be), 32'(!s.err));
        compare("chip_selects", 32'(cs), 32'(s.cs));
        if (s.rd_wr && !s.err) compare("rdata", 32'(rd), 32'(s.rd_exp));
        compare("dtack_n after cycle", 32'(dtack_n), 32'd1);
        compare("chip_selects after cycle", 32'({rom_cs, vram_cs, char_cs, objram_cs,
                pal_cs, ram_cs}), 32'(cs_none));
    endtask

    initial begin
        int n;
        int i;
        int cen_count;
        int cenb_count;
        rst = 1'b1;
        game_id = game_default;
        addr = '0;
        as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rnw = 1'b1;
        fc = 3'd0;
        wdata = 16'h0000;
        rom_data = rom_word;
        ram_data = ram_word;
        char_dout = char_word;
        pal_dout = pal_word;
        obj_dout = obj_word;
        vdump = 9'd0;
        hstart = 1'b0;
        snd_ack = 1'b0;
        joystick1 = joy1_val;
        joystick2 = joy2_val;
        joyana1 = ana1_val;
        joyana2 = ana2_val;
        start_button = start_val;
        coin_input = coin_val;
        service = service_val;
        dip_test = test_val;
        dipsw_a = dip_a_val;
        dipsw_b = dip_b_val;

        // Memory map
        read_entry(24'h012344, game_default, rom_word, cs_rom);
        read_entry(24'h03fffe, game_default, rom_word, cs_rom);
        read_entry(24'h400010, game_default, ram_word, cs_vram);
        read_entry(24'h410020, game_default, char_word, cs_char);
        read_entry(24'h440100, game_default, obj_word, cs_obj);
        read_entry(24'h840200, game_default, pal_word, cs_pal);
        read_entry(24'hc70400, game_default, ram_word, cs_ram);
        write_entry(24'hc70402, 16'hbeef, cs_ram);
        write_entry(24'hc60000, 16'h0000, cs_none);  // Watchdog
        read_entry(24'hc43000, game_default, 16'hffff, cs_none);
        fault_entry(24'h800000);
        fault_entry(24'h040000);
        fault_entry(24'h420000);
        // Port B bit 2 still set from reset for the cabinet and DIP reads
        read_entry(24'hc41000, game_default, {8'hff, cab_word0(game_default)}, cs_none);
        read_entry(24'hc41002, game_default, {8'hff, wired_joy(joy1_val)}, cs_none);
        read_entry(24'hc41006, game_default, {8'hff, wired_joy(joy2_val)}, cs_none);
        read_entry(24'hc42000, game_default, {8'hff, dip_a_val}, cs_none);
        read_entry(24'hc42002, game_default, {8'hff, dip_b_val}, cs_none);
        read_entry(24'hc41000, game_sdi, {8'hff, cab_word0(game_sdi)}, cs_none);
        read_entry(24'hc41002, game_sdi, {8'hff, ~ana1_val[15:8]}, cs_none);
        read_entry(24'hc41006, game_sdi, {8'hff, ~ana2_val[15:8]}, cs_none);
        read_entry(24'hc42002, game_sdi, {8'hff, dip_b_val}, cs_none);
        // PPI ports
        write_entry(24'hc40000, 16'h005a, cs_none);
        read_entry(24'hc40000, game_default, 16'hff5a, cs_none);
        write_entry(24'hc40002, 16'h0080, cs_none);
        read_entry(24'hc40002, game_default, 16'hff80, cs_none);
        read_entry(24'hc41002, game_sdi, {8'hff, ana1_val[7:0]}, cs_none);
        read_entry(24'hc41006, game_sdi, {8'hff, ana2_val[7:0]}, cs_none);
        write_entry(24'hc40006, 16'h000e, cs_none);  // Clear C7
        write_entry(24'hc40006, 16'h0004, cs_none);  // Clear C2
        write_entry(24'hc40006, 16'h0002, cs_none);  // Clear C1
        read_entry(24'hc40004, game_default, 16'hff39, cs_none);  // Port C 79 with snd_ack low

        repeat (16) @(negedge clk);
        rst = 1'b0;

        foreach (steps[k]) run_step(steps[k], 3'd5);

        compare("snd_latch", 32'(snd_latch), 32'h5a);
        compare("flip", 32'(flip), 32'd1);
        compare("snd_irqn", 32'(snd_irqn), 32'd0);
        compare("colscr_en", 32'(colscr_en), 32'd1);
        compare("rowscr_en", 32'(rowscr_en), 32'd1);
        snd_ack = 1'b1;
        run_step({24'hc40004, 1'b1, 16'h0000, game_default, 16'hff79, 1'b0, cs_none}, 3'd5);
        // Set C2
        run_step({24'hc40006, 1'b0, 16'h0005, game_default, 16'h0000, 1'b0, cs_none}, 3'd5);
        compare("colscr_en", 32'(colscr_en), 32'd0);
        compare("rowscr_en", 32'(rowscr_en), 32'd1);
        run_step({24'hc40002, 1'b0, 16'h007f, game_default, 16'h0000, 1'b0, cs_none}, 3'd5);
        compare("flip", 32'(flip), 32'd0);
        // Mode set brings every port back to ones
        run_step({24'hc40006, 1'b0, 16'h0080, game_default, 16'h0000, 1'b0, cs_none}, 3'd5);
        compare("snd_latch", 32'(snd_latch), 32'hff);
        compare("flip", 32'(flip), 32'd1);
        compare("snd_irqn", 32'(snd_irqn), 32'd1);
        compare("rowscr_en", 32'(rowscr_en), 32'd0);

        // Line start outside VBLANK
        vdump = 9'd100;
        hstart = 1'b1;
        @(negedge clk);
        hstart = 1'b0;
        repeat (4) @(negedge clk);
        compare("irq_n", 32'(irq_n), 32'd1);
        vdump = vblank_line;
        hstart = 1'b1;
        @(negedge clk);
        hstart = 1'b0;
        n = 0;
        while (irq_n) begin
            @(negedge clk);
            n++;
            if (n > 8) abort_timeout("irq_n to fall");
        end
        // Interrupt acknowledge ends in a bus error without autovector
        run_step({24'hfffff6, 1'b1, 16'h0000, game_default, 16'hffff, 1'b1, cs_none}, 3'd7);
        compare("irq_n", 32'(irq_n), 32'd1);

        cen_count = 0;
        cenb_count = 0;
        for (i = 0; i < idle_cycles; i++) begin
            @(negedge clk);
            if (cpu_cen) cen_count++;
            if (cpu_cenb) cenb_count++;
        end
        compare("cpu_cen pulses", 32'(cen_count), 32'(idle_cycles * cen_num / cen_den));
        compare("cpu_cenb pulses", 32'(cenb_count), 32'(idle_cycles * cen_num / cen_den));

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/s16_main_glue.sv ====
/* Main CPU glue top level: bus control, clock enable, cabinet I/O,
   PPI and VBLANK interrupt */
`timescale 1ns/10ps
`default_nettype none

module s16_main_glue import s16_pkg::*; #(
    parameter int cen_num = 29,
    parameter int cen_den = 146
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        game_id,
    // CPU bus
    input  logic [addr_w:1]   addr,
    input  logic              as_n,
    input  logic              uds_n,
    input  logic              lds_n,
    input  logic              rnw,
    input  logic [2:0]        fc,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata,
    output logic              dtack_n,
    output logic              berr_n,
    output logic              irq_n,
    output logic              cpu_cen,
    output logic              cpu_cenb,
    // Memories
    output logic              rom_cs,
    output logic              char_cs,
    output logic              objram_cs,
    output logic              pal_cs,
    output logic              vram_cs,
    output logic              ram_cs,
    output logic [17:1]       rom_addr,
    input  logic [data_w-1:0] rom_data,
    input  logic [data_w-1:0] ram_data,
    input  logic [data_w-1:0] char_dout,
    input  logic [data_w-1:0] pal_dout,
    input  logic [data_w-1:0] obj_dout,
    input  logic              rom_ok,
    input  logic              ram_ok,
    // Video
    input  logic [8:0]        vdump,
    input  logic              hstart,
    output logic              flip,
    output logic              colscr_en,
    output logic              rowscr_en,
    // Sound
    output logic [7:0]        snd_latch,
    output logic              snd_irqn,
    input  logic              snd_ack,
    // Cabinet
    input  logic [7:0]        joystick1,
    input  logic [7:0]        joystick2,
    input  logic [15:0]       joyana1,
    input  logic [15:0]       joyana2,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  logic              dip_test,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b
);

    region_t    io_sel;
    logic [1:0] io_addr, ppi_addr;
    logic       ppi_cs, ppi_we, bus_busy;
    logic [7:0] cab_dout, ppi_dout, ppi_portb, ppi_portc;

    assign rom_addr  = addr[17:1];
    assign snd_irqn  = ppi_portc[7];
    assign colscr_en = ~ppi_portc[2];
    assign rowscr_en = ~ppi_portc[1];
    assign flip      = ppi_portb[7];

    s16_bus_ctrl u_bus_ctrl (
        .clk(clk), .rst(rst), .addr(addr), .as_n(as_n), .uds_n(uds_n),
        .lds_n(lds_n), .rnw(rnw), .cpu_cen(cpu_cen),
        .char_dout(char_dout), .pal_dout(pal_dout), .obj_dout(obj_dout),
        .ram_data(ram_data), .rom_data(rom_data), .ram_ok(ram_ok),
        .rom_ok(rom_ok), .cab_dout(cab_dout),
        .rom_cs(rom_cs), .char_cs(char_cs), .objram_cs(objram_cs),
        .pal_cs(pal_cs), .vram_cs(vram_cs), .ram_cs(ram_cs),
        .io_sel(io_sel), .io_addr(io_addr), .ppi_cs(ppi_cs), .ppi_we(ppi_we),
        .ppi_addr(ppi_addr), .bus_busy(bus_busy), .rdata(rdata),
        .dtack_n(dtack_n), .berr_n(berr_n)
    );

    s16_cen_gen #(.cen_num(cen_num), .cen_den(cen_den)) u_cen_gen (
        .clk(clk), .rst(rst), .bus_busy(bus_busy),
        .cpu_cen(cpu_cen), .cpu_cenb(cpu_cenb)
    );

    s16_cab_io u_cab_io (
        .clk(clk), .rst(rst), .game_id(game_id), .io_sel(io_sel),
        .io_addr(io_addr), .ppi_dout(ppi_dout), .ppi_portb(ppi_portb),
        .joystick1(joystick1), .joystick2(joystick2), .joyana1(joyana1),
        .joyana2(joyana2), .start_button(start_button), .coin_input(coin_input),
        .service(service), .dip_test(dip_test), .dipsw_a(dipsw_a),
        .dipsw_b(dipsw_b), .cab_dout(cab_dout)
    );

    s16_ppi u_ppi (
        .clk(clk), .rst(rst), .ppi_cs(ppi_cs), .ppi_we(ppi_we),
        .ppi_addr(ppi_addr), .wdata(wdata[7:0]), .snd_ack(snd_ack),
        .ppi_dout(ppi_dout), .snd_latch(snd_latch), .ppi_portb(ppi_portb),
        .ppi_portc(ppi_portc)
    );

    s16_vblank_irq u_vblank_irq (
        .clk(clk), .rst(rst), .vdump(vdump), .hstart(hstart),
        .fc(fc), .as_n(as_n), .irq_n(irq_n)
    );

endmodule

`default_nettype wire

// ==== verilog/s16_bus_ctrl.sv ====
/* Main bus control: memory-map decode, chip selects, read-data register,
   DTACK with wait states and bus error */
`timescale 1ns/10ps
`default_nettype none

module s16_bus_ctrl import s16_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [addr_w:1]   addr,
    input  logic              as_n,
    input  logic              uds_n,
    input  logic              lds_n,
    input  logic              rnw,
    input  logic              cpu_cen,
    input  logic [data_w-1:0] char_dout,
    input  logic [data_w-1:0] pal_dout,
    input  logic [data_w-1:0] obj_dout,
    input  logic [data_w-1:0] ram_data,
    input  logic [data_w-1:0] rom_data,
    input  logic              ram_ok,
    input  logic              rom_ok,
    input  logic [7:0]        cab_dout,
    output logic              rom_cs,
    output logic              char_cs,
    output logic              objram_cs,
    output logic              pal_cs,
    output logic              vram_cs,
    output logic              ram_cs,
    output region_t           io_sel,
    output logic [1:0]        io_addr,
    output logic              ppi_cs,
    output logic              ppi_we,
    output logic [1:0]        ppi_addr,
    output logic              bus_busy,
    output logic [data_w-1:0] rdata,
    output logic              dtack_n,
    output logic              berr_n
);

    region_t nxt, rgn;
    logic    bus_sel;   // Address strobe with a data strobe
    logic    act;       // Cycle seen on the previous clock
    logic    held;      // Select valid for a full cycle
    logic    berr_q;

    assign bus_sel = !as_n && !(uds_n && lds_n);

    always_comb begin
        nxt = rgn_none;
        if (addr[23:22] == 2'd0 && !addr[18]) begin
            nxt = rgn_rom;  // 00-03
        end else begin
            case (addr[23:16])
                8'h40: nxt = rgn_vram;
                8'h41: nxt = rgn_char;
                8'h44: nxt = rgn_objram;
                8'h84: nxt = rgn_pal;
                8'hc4: begin
                    case (addr[13:12])
                        2'd0:    nxt = rgn_io_ppi;
                        2'd1:    nxt = rgn_io_cab;
                        2'd2:    nxt = rgn_io_dip;
                        default: nxt = rgn_io;
                    endcase
                end
                8'hc6: nxt = rgn_wdog;  // Decoded only
                8'hc7: nxt = rgn_ram;
                default: nxt = rgn_none;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgn     <= rgn_none;
            io_addr <= 2'd0;
            act     <= 1'b0;
            held    <= 1'b0;
            ppi_we  <= 1'b0;
            berr_q  <= 1'b0;
            dtack_n <= 1'b1;
        end else begin
            act    <= bus_sel;
            held   <= bus_sel && act;
            ppi_we <= bus_sel && !act && nxt == rgn_io_ppi && !rnw && !lds_n;
            berr_q <= bus_sel && act && rgn == rgn_none;  // Unmapped
            rgn    <= bus_sel ? nxt : rgn_none;
            if (bus_sel) io_addr <= addr[2:1];
            if (as_n) begin
                dtack_n <= 1'b1;
            end else if (held && rgn != rgn_none && cpu_cen && !bus_busy) begin
                dtack_n <= 1'b0;
            end
        end
    end

    // Sample the source until DTACK goes out
    always_ff @(posedge clk) begin
        if (dtack_n) begin
            case (rgn)
                rgn_rom:            rdata <= rom_data;
                rgn_vram, rgn_ram:  rdata <= ram_data;
                rgn_char:           rdata <= char_dout;
                rgn_objram:         rdata <= obj_dout;
                rgn_pal:            rdata <= pal_dout;
                rgn_io_ppi, rgn_io_cab, rgn_io_dip:
                                    rdata <= {8'hff, cab_dout};
                default:            rdata <= {data_w{1'b1}};
            endcase
        end
    end

    assign rom_cs    = rgn == rgn_rom;
    assign char_cs   = rgn == rgn_char;
    assign objram_cs = rgn == rgn_objram;
    assign pal_cs    = rgn == rgn_pal;
    assign vram_cs   = rgn == rgn_vram;
    assign ram_cs    = rgn == rgn_ram;
    assign ppi_cs    = rgn == rgn_io_ppi;
    assign io_sel    = rgn;
    assign ppi_addr  = io_addr;

    // SDRAM not ready yet
    assign bus_busy = (rom_cs && !rom_ok) || ((ram_cs || vram_cs) && !ram_ok);
    assign berr_n   = !berr_q || as_n;

endmodule

`default_nettype wire

// ==== verilog/s16_vblank_irq.sv ====
/* VBLANK interrupt request, set at line start and cleared by the
   interrupt acknowledge cycle */
`timescale 1ns/10ps
`default_nettype none

module s16_vblank_irq import s16_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [8:0] vdump,
    input  logic       hstart,
    input  logic [2:0] fc,
    input  logic       as_n,
    output logic       irq_n
);

    logic last_hstart;
    logic inta;

    assign inta = fc == 3'd7 && !as_n;  // CPU space cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_n       <= 1'b1;
            last_hstart <= 1'b0;
        end else begin
            last_hstart <= hstart;
            if (inta) begin
                irq_n <= 1'b1;
            end else if (hstart && !last_hstart && vdump == vblank_line) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/s16_ppi.sv ====
/* Mode-0 8255-style parallel interface, three output ports
   and the control word with port C bit set/reset */
`timescale 1ns/10ps
`default_nettype none

module s16_ppi (
    input  logic       clk,
    input  logic       rst,
    input  logic       ppi_cs,
    input  logic       ppi_we,
    input  logic [1:0] ppi_addr,
    input  logic [7:0] wdata,
    input  logic       snd_ack,
    output logic [7:0] ppi_dout,
    output logic [7:0] snd_latch,
    output logic [7:0] ppi_portb,
    output logic [7:0] ppi_portc
);

    logic [7:0] porta, portb, portc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            porta <= 8'h00;   // Sound latch starts clear
            portb <= 8'hff;
            portc <= 8'hff;
        end else if (ppi_cs && ppi_we) begin
            case (ppi_addr)
                2'd0: porta <= wdata;
                2'd1: portb <= wdata;
                2'd2: portc <= wdata;
                default: begin
                    if (wdata[7]) begin
                        // Mode set
                        porta <= 8'hff;
                        portb <= 8'hff;
                        portc <= 8'hff;
                    end else begin
                        portc[wdata[3:1]] <= wdata[0];  // Bit set/reset
                    end
                end
            endcase
        end
    end

    // Port C bit 6 is an input from the sound CPU
    always_comb begin
        case (ppi_addr)
            2'd0:    ppi_dout = porta;
            2'd1:    ppi_dout = portb;
            2'd2:    ppi_dout = {portc[7], snd_ack, portc[5:0]};
            default: ppi_dout = 8'hff;
        endcase
    end

    assign snd_latch = porta;
    assign ppi_portb = portb;
    assign ppi_portc = portc;

endmodule

`default_nettype wire

// ==== verilog/s16_cab_io.sv ====
/* Cabinet input multiplexer: PPI read-back, coin and start bits,
   joysticks reordered per game and DIP switch banks */
`timescale 1ns/10ps
`default_nettype none

module s16_cab_io import s16_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  game_id,
    input  region_t     io_sel,
    input  logic [1:0]  io_addr,
    input  logic [7:0]  ppi_dout,
    input  logic [7:0]  ppi_portb,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [15:0] joyana1,
    input  logic [15:0] joyana2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    output logic [7:0]  cab_dout
);

    logic       is_sdi;
    logic [7:0] sort1, sort2;
    logic [7:0] ana1, ana2;

    // Board wiring of the joystick connector
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        sort_joy = {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    assign is_sdi = game_id == game_sdi;
    assign sort1  = sort_joy(joystick1);
    assign sort2  = sort_joy(joystick2);

    // Port B bit 2 picks the high byte of the analog inputs
    assign ana1 = ppi_portb[2] ? ~joyana1[15:8] : joyana1[7:0];
    assign ana2 = ppi_portb[2] ? ~joyana2[15:8] : joyana2[7:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout <= 8'hff;
        end else begin
            cab_dout <= 8'hff;  // Nothing selected
            case (io_sel)
                rgn_io_ppi: cab_dout <= ppi_dout;
                rgn_io_cab: begin
                    case (io_addr)
                        2'd0: begin
                            cab_dout <= {2'b11, start_button, service, dip_test, coin_input};
                            if (is_sdi) begin
                                cab_dout[7] <= joystick2[4];  // Fire buttons
                                cab_dout[6] <= joystick1[4];
                            end
                        end
                        2'd1: cab_dout <= is_sdi ? ana1 : sort1;
                        2'd2: begin
                            if (is_sdi) cab_dout <= {sort2[7:4], sort1[7:4]};
                        end
                        default: cab_dout <= is_sdi ? ana2 : sort2;
                    endcase
                end
                rgn_io_dip: cab_dout <= io_addr[0] ? dipsw_b : dipsw_a;
                default: cab_dout <= 8'hff;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/s16_cen_gen.sv ====
/* Fractional CPU clock enable with a half-period second phase,
   frozen while the bus waits for memory */
`timescale 1ns/10ps
`default_nettype none

module s16_cen_gen #(
    parameter int cen_num = 29,
    parameter int cen_den = 146
) (
    input  logic clk,
    input  logic rst,
    input  logic bus_busy,
    output logic cpu_cen,
    output logic cpu_cenb
);

    localparam int aw = $clog2(cen_den) + 1;  // Room for acc + num

    localparam logic [aw-1:0] num  = aw'(cen_num);
    localparam logic [aw-1:0] den  = aw'(cen_den);
    localparam logic [aw-1:0] half = aw'(cen_den / 2);

    logic [aw-1:0] acc;
    logic [aw-1:0] sum;
    logic          wrap;

    assign sum  = acc + num;
    assign wrap = sum >= den;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc      <= '0;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else if (bus_busy) begin
            cpu_cen  <= 1'b0;   // Accumulator holds
            cpu_cenb <= 1'b0;
        end else begin
            cpu_cen  <= wrap;
            // Crossing the midpoint gives the second phase
            cpu_cenb <= acc < half && sum >= half;
            acc      <= wrap ? sum - den : sum;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/s16_pkg.sv ====
/* Shared definitions for the main CPU glue: game identifiers,
   decoded memory-map regions and bus widths */
`default_nettype none

package s16_pkg;

    // Game identifiers, anything but game_sdi runs as the default game
    localparam logic [7:0] game_default = 8'h00;
    localparam logic [7:0] game_sdi     = 8'h01;  // Analog-input cabinet

    localparam int addr_w = 23;  // Word address, bits 23 to 1
    localparam int data_w = 16;

    // Line where the VBLANK interrupt fires
    localparam logic [8:0] vblank_line = 9'd223;

    // Decoded regions; the I/O area is split by address bits 13:12
    typedef enum logic [3:0] {
        rgn_none   = 4'd0,
        rgn_rom    = 4'd1,
        rgn_vram   = 4'd2,
        rgn_char   = 4'd3,
        rgn_objram = 4'd4,
        rgn_pal    = 4'd5,
        rgn_io     = 4'd6,   // Unused I/O slot, reads ones
        rgn_wdog   = 4'd7,
        rgn_ram    = 4'd8,
        rgn_io_ppi = 4'd9,   // 8255
        rgn_io_cab = 4'd10,  // Cabinet inputs
        rgn_io_dip = 4'd11   // DIP switches
    } region_t;

endpackage

`default_nettype wire
